//--- sim.f
+incdir+bench
src/rvPkg.sv
src/decodeIf.sv
src/instDecoder.sv
src/regFile.sv
src/intAlu.sv
src/branchUnit.sv
src/riscCore.sv
bench/coreBench.sv

//--- run.sh
#!/usr/bin/env bash
# builds the core with its testbench and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module coreBench \
    -f sim.f \
    -o coreSim

./obj_dir/coreSim

//--- bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] lfsrState = 32'h68bcf5dd;
logic [31:0] modelPc;
logic [31:0] modelRegs [32];
logic [31:0] modelMem [256];
logic expWen;
logic expHalt;
logic [31:0] expAddr;
logic [31:0] expData;

// galois lfsr, one step per bit handed out
function automatic logic [31:0] randBits(int count);
    logic [31:0] value;
    logic outBit;
    value = '0;
    for (int i = 0; i < count; i++) begin
        outBit = lfsrState[0];
        lfsrState = (lfsrState >> 1) ^ (outBit ? 32'ha3000000 : 32'h0);
        value = {value[30:0], outBit};
    end
    return value;
endfunction

function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] x,
                                       logic [31:0] y);
    case (f3)
        3'd0: return alt ? x - y : x + y;
        3'd1: return x << y[4:0];
        3'd2: return {31'b0, $signed(x) < $signed(y)};
        3'd3: return {31'b0, x < y};
        3'd4: return x ^ y;
        3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6: return x | y;
        default: return x & y;
    endcase
endfunction

// one architectural step from modelPc, expectations land in exp*
function automatic void isaStep();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] result;
    logic [31:0] nextPc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic writeRd;
    logic taken;
    inst = instMem[modelPc[9:2]];
    f3 = inst[14:12];
    f7 = inst[31:25];
    a = modelRegs[inst[19:15]];
    b = modelRegs[inst[24:20]];
    immI = 32'($signed(inst[31:20]));
    immS = 32'($signed({inst[31:25], inst[11:7]}));
    immB = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    immJ = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
    nextPc = modelPc + 32'd4;
    result = '0;
    writeRd = 1'b1;
    expWen = 1'b0;
    expHalt = 1'b0;
    expAddr = '0;
    expData = '0;
    case (inst[6:0])
        7'h33: begin
            expHalt = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            result = aluRef(f3, f7[5], a, b);
        end
        7'h13: begin
            expHalt = (f3 == 3'd1 && f7 != 7'h00) ||
                      (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            result = aluRef(f3, f3 == 3'd5 && f7[5], a, immI);
        end
        7'h37: result = {inst[31:12], 12'h0};
        7'h17: result = modelPc + {inst[31:12], 12'h0};
        7'h6f: begin
            result = modelPc + 32'd4;
            nextPc = modelPc + immJ;
        end
        7'h67: begin
            result = modelPc + 32'd4;
            nextPc = (a + immI) & ~32'h1;
            expHalt = (f3 != 3'd0);
        end
        7'h63: begin
            case (f3)
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = ($signed(a) < $signed(b));
                3'd5: taken = ($signed(a) >= $signed(b));
                3'd6: taken = (a < b);
                3'd7: taken = (a >= b);
                default: taken = 1'b0;
            endcase
            if (taken) begin
                nextPc = modelPc + immB;
            end
            expHalt = (f3 == 3'd2) || (f3 == 3'd3);
            writeRd = 1'b0;
        end
        7'h03: begin
            expAddr = a + immI;
            expHalt = (f3 != 3'd2) || (expAddr[1:0] != 2'b00);
            result = modelMem[expAddr[9:2]];
        end
        7'h23: begin
            expAddr = a + immS;
            expHalt = (f3 != 3'd2) || (expAddr[1:0] != 2'b00);
            expData = b;
            expWen = !expHalt;
            writeRd = 1'b0;
        end
        default: expHalt = 1'b1; // unknown opcode
    endcase
    if (!expHalt) begin
        if (expWen) begin
            modelMem[expAddr[9:2]] = expData;
        end
        if (writeRd && inst[11:7] != 5'd0) begin
            modelRegs[inst[11:7]] = result;
        end
        modelPc = nextPc;
    end
endfunction

`endif

//--- bench/coreBench.sv
`timescale 1ns/1ps

module coreBench;

    logic clk = 1'b0;
    logic rst = 1'b0;
    logic [31:0] instWord;
    logic [31:0] dataRead;
    logic [31:0] pc;
    logic [31:0] dataAddr;
    logic [31:0] dataWrite;
    logic dataWen;
    logic halt;

    logic [31:0] instMem [256];
    logic [31:0] dataMem [256];
    string instTag [256];
    string curTag;
    int progLen;
    int storeOff;
    int timeoutLimit;
    int cycleCount = 0;
    int haltCount = 0;
    int activeRun = 0;
    int doneRuns = 0;

    `include "isaModel.svh"

    riscCore #(.ResetPc(32'h0)) UUT (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .instWord  (instWord),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataWen   (dataWen),
        .dataRead  (dataRead),
        .halt      (halt)
    );

    always #2 clk = ~clk;

    assign instWord = instMem[pc[9:2]];
    assign dataRead = dataMem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (dataWen) begin
            dataMem[dataAddr[9:2]] <= dataWrite;
        end
    end

    task automatic emit(logic [31:0] word, string tag);
        instMem[progLen] = word;
        instTag[progLen] = tag;
        progLen++;
    endtask

    task automatic setReg(logic [4:0] rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800; // addi sign extends its low part
        emit({upper[31:12], rd, 7'h37}, "setup");
        emit({value[11:0], rd, 3'd0, rd, 7'h13}, "setup");
    endtask

    task automatic storeReg(logic [4:0] rs, string tag);
        logic [11:0] off;
        off = 12'(storeOff);
        emit({off[11:5], rs, 5'd0, 3'd2, off[4:0], 7'h23}, tag);
        storeOff += 4;
    endtask

    task automatic buildProgram(int haltKind);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        logic [31:0] r;
        logic [4:0] rsA;
        logic [4:0] rsB;
        int target;
        progLen = 0;
        storeOff = 'h200;
        for (int i = 0; i < 256; i++) begin
            instMem[i] = 32'h0; // opcode zero is unknown
            dataMem[i] = ((32'(i) << 2) * 32'h9e3779b1) ^ 32'hc3a50000;
        end
        setReg(5'd1, randBits(32));
        setReg(5'd2, randBits(32) | 32'h80000000); // negative
        setReg(5'd3, randBits(32) & 32'h7fffffff); // positive
        emit({12'd0, 5'd1, 3'd0, 5'd4, 7'h13}, "setup"); // x4 equals x1
        for (int f = 0; f < 10; f++) begin
            f3 = (f == 8) ? 3'd0 : (f == 9) ? 3'd5 : 3'(f); // 8 and 9 are sub, sra
            f7 = (f >= 8) ? 7'h20 : 7'h00;
            emit({f7, 5'd2, 5'd1, f3, 5'd10, 7'h33}, "arith");
            storeReg(5'd10, "arith");
            emit({f7, 5'd3, 5'd2, f3, 5'd10, 7'h33}, "arith");
            storeReg(5'd10, "arith");
        end
        for (int f = 0; f < 9; f++) begin
            f3 = (f == 8) ? 3'd5 : 3'(f);
            imm = 12'(randBits(12));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {(f == 8) ? 7'h20 : 7'h00, imm[4:0]};
            end
            emit({imm, 5'd2, f3, 5'd11, 7'h13}, "arith imm");
            storeReg(5'd11, "arith imm");
        end
        emit({20'(randBits(20)), 5'd12, 7'h37}, "lui");
        storeReg(5'd12, "lui");
        emit({20'(randBits(20)), 5'd12, 7'h17}, "auipc");
        storeReg(5'd12, "auipc");
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd13, 7'h6f}, "jal"); // over the next one
        emit({12'd1, 5'd0, 3'd0, 5'd13, 7'h13}, "jal");
        storeReg(5'd13, "jal");
        target = (progLen + 3) * 4;
        emit({12'(target + 1), 5'd0, 3'd0, 5'd14, 7'h13}, "jalr"); // odd on purpose
        emit({12'd0, 5'd14, 3'd0, 5'd15, 7'h67}, "jalr");
        emit({12'd1, 5'd0, 3'd0, 5'd15, 7'h13}, "jalr");
        storeReg(5'd15, "jalr");
        emit({12'd0, 5'd0, 3'd0, 5'd16, 7'h13}, "branch");
        for (int bf = 0; bf < 8; bf++) begin
            if (bf != 2 && bf != 3) begin
                for (int p = 0; p < 3; p++) begin
                    r = randBits(1);
                    rsA = (p == 1) ? 5'd2 : 5'd1;
                    rsB = (p == 0) ? 5'd4 : (p == 1) ? 5'd3 : 5'd2;
                    if (r[0]) begin
                        {rsA, rsB} = {rsB, rsA};
                    end
                    emit({7'd0, rsB, rsA, 3'(bf), 4'd4, 1'b0, 7'h63}, "branch");
                    emit({12'd1, 5'd16, 3'd0, 5'd16, 7'h13}, "branch"); // counts not taken
                end
            end
        end
        storeReg(5'd16, "branch");
        emit({12'h200, 5'd0, 3'd2, 5'd17, 7'h03}, "load"); // first stored word
        storeReg(5'd17, "load");
        emit({12'h3f0, 5'd0, 3'd2, 5'd18, 7'h03}, "load"); // untouched fill word
        storeReg(5'd18, "load");
        emit({12'd5, 5'd0, 3'd0, 5'd0, 7'h13}, "x0");
        storeReg(5'd0, "x0");
        r = randBits(25);
        case (haltKind)
            0: emit({r[24:0], 7'h7f}, "halt opcode");
            1: emit({7'd0, 5'd2, 5'd1, 3'd2, 4'd4, 1'b0, 7'h63}, "halt branch");
            2: emit({7'h01, 5'd2, 5'd1, 3'd0, 5'd10, 7'h33}, "halt funct7");
            default: emit({7'd0, 5'd1, 5'd0, 3'd2, 5'd6, 7'h23}, "halt misaligned");
        endcase
        timeoutLimit = 2 * progLen + 20;
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (activeRun != doneRuns) begin
            if (cycleCount == 0) begin
                modelPc = 32'h0; // model leaves reset with the core
                for (int i = 0; i < 32; i++) begin
                    modelRegs[i] = '0;
                end
                modelMem = dataMem;
            end
            curTag = instTag[modelPc[9:2]];
            checkValue({curTag, " pc"}, modelPc, pc);
            isaStep();
            checkValue({curTag, " dataWen"}, 32'(expWen), 32'(dataWen));
            if (expWen) begin
                checkValue({curTag, " dataAddr"}, expAddr, dataAddr);
                checkValue({curTag, " dataWrite"}, expData, dataWrite);
            end
            checkValue({curTag, " halt"}, 32'(expHalt), 32'(halt));
            cycleCount++;
            if (expHalt) begin
                haltCount++;
            end
            if (haltCount == 4) begin
                doneRuns = activeRun; // a few frozen cycles seen
                haltCount = 0;
                cycleCount = 0;
            end else if (cycleCount > timeoutLimit) begin
                $display("test failed");
                $fatal(1, "timeout, core did not halt within %0d cycles", timeoutLimit);
            end
        end
    end

    initial begin
        for (int run = 0; run < 4; run++) begin
            buildProgram(run); // rst is low here
            repeat (3) @(posedge clk);
            rst <= 1'b1;
            activeRun = run + 1;
            wait (doneRuns == run + 1);
            @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- src/riscCore.sv
`timescale 1ns/1ps

module riscCore #(
    parameter rvPkg::word_t ResetPc = '0
) (
    input logic clk,
    input logic rst,
    output rvPkg::word_t pc,
    input rvPkg::word_t instWord,
    output rvPkg::word_t dataAddr,
    output rvPkg::word_t dataWrite,
    output logic dataWen,
    input rvPkg::word_t dataRead,
    output logic halt
);

    decodeIf decBus ();

    rvPkg::word_t rs1Data;
    rvPkg::word_t rs2Data;
    rvPkg::word_t aluResult;
    rvPkg::word_t nextPc;
    rvPkg::word_t rdData;
    logic aluIllegal;
    logic branchIllegal;
    logic opKnown;
    logic writesRd;
    logic isLoad;
    logic isStore;
    logic memIllegal;
    logic regWen;

    instDecoder decoder (
        .instWord (instWord),
        .dec      (decBus)
    );

    regFile regs (
        .clk     (clk),
        .rst     (rst),
        .rs1     (decBus.rs1),
        .rs2     (decBus.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rd      (decBus.rd),
        .rdData  (rdData),
        .wen     (regWen)
    );

    intAlu alu (
        .dec     (decBus),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .result  (aluResult),
        .illegal (aluIllegal)
    );

    branchUnit branch (
        .dec     (decBus),
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .nextPc  (nextPc),
        .illegal (branchIllegal)
    );

    // writeback source per opcode
    always_comb begin
        opKnown = 1'b1;
        writesRd = 1'b1;
        rdData = aluResult;
        case (decBus.opcode)
            rvPkg::OP, rvPkg::OP_IMM: rdData = aluResult;
            rvPkg::LOAD:              rdData = dataRead;
            rvPkg::JAL, rvPkg::JALR:  rdData = pc + rvPkg::INST_BYTES; // link address
            rvPkg::LUI:               rdData = decBus.immU;
            rvPkg::AUIPC:             rdData = pc + decBus.immU;
            rvPkg::STORE, rvPkg::BRANCH: writesRd = 1'b0;
            default: begin
                opKnown = 1'b0; // unknown opcode
                writesRd = 1'b0;
            end
        endcase
    end

    assign isLoad = (decBus.opcode == rvPkg::LOAD);
    assign isStore = (decBus.opcode == rvPkg::STORE);

    assign dataAddr = rs1Data + (isStore ? decBus.immS : decBus.immI);
    assign dataWrite = rs2Data;

    // word access only, and it must be aligned
    assign memIllegal = (isLoad || isStore) &&
                        ((decBus.funct3 != rvPkg::FUNCT3_WORD) || (dataAddr[1:0] != 2'b00));

    assign halt = !opKnown || memIllegal || aluIllegal || branchIllegal;

    // nothing architectural changes once halted or in reset
    assign dataWen = isStore && !halt && rst;
    assign regWen = writesRd && !halt && rst;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= ResetPc;
        end else if (!halt) begin
            pc <= nextPc; // frozen while halted
        end
    end

    assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

//--- src/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
    decodeIf.consumer dec,
    input rvPkg::word_t pc,
    input rvPkg::word_t rs1Data,
    input rvPkg::word_t rs2Data,
    output rvPkg::word_t nextPc,
    output logic illegal
);

    rvPkg::branchOp_t brOp;
    logic unsignedLess;
    logic signedLess;
    logic taken;
    rvPkg::word_t jalrSum;

    assign brOp = rvPkg::branchOp_t'(dec.funct3);
    assign unsignedLess = (rs1Data < rs2Data);
    assign signedLess = (rs1Data[rvPkg::XLEN-1] != rs2Data[rvPkg::XLEN-1]) ?
                        rs1Data[rvPkg::XLEN-1] : unsignedLess;
    assign jalrSum = rs1Data + dec.immI;

    always_comb begin
        case (brOp)
            rvPkg::BR_EQ:  taken = (rs1Data == rs2Data);
            rvPkg::BR_NE:  taken = (rs1Data != rs2Data);
            rvPkg::BR_LT:  taken = signedLess;
            rvPkg::BR_GE:  taken = !signedLess;
            rvPkg::BR_LTU: taken = unsignedLess;
            rvPkg::BR_GEU: taken = !unsignedLess;
            default:       taken = 1'b0; // codes 2 and 3
        endcase
    end

    always_comb begin
        nextPc = pc + rvPkg::INST_BYTES; // fall through
        illegal = 1'b0;
        case (dec.opcode)
            rvPkg::BRANCH: begin
                if (taken) begin
                    nextPc = pc + dec.immB;
                end
                illegal = (dec.funct3 == 3'd2) || (dec.funct3 == 3'd3);
            end
            rvPkg::JAL:  nextPc = pc + dec.immJ;
            rvPkg::JALR: begin
                nextPc = {jalrSum[rvPkg::XLEN-1:1], 1'b0}; // clear bit 0
                illegal = (dec.funct3 != 3'd0);
            end
            default: ;
        endcase
    end

    // branch offsets stay multiples of four in a legal program
    always_comb begin
        if ((dec.opcode == rvPkg::BRANCH) && !illegal) begin
            assert (nextPc[1:0] == 2'b00)
                else $error("branch target not word aligned");
        end
    end

endmodule

//--- src/intAlu.sv
`timescale 1ns/1ps

module intAlu (
    decodeIf.consumer dec,
    input rvPkg::word_t rs1Data,
    input rvPkg::word_t rs2Data,
    output rvPkg::word_t result,
    output logic illegal
);

    logic isOp;
    logic isOpImm;
    rvPkg::aluOp_t aluOp;
    rvPkg::word_t opB;
    logic [6:0] upper;
    logic upperZero;
    logic upperAlt;
    logic upperBad;
    logic [4:0] shamt;
    logic unsignedLess;
    logic signedLess;
    rvPkg::word_t srlValue;
    rvPkg::word_t sraValue;

    assign isOp = (dec.opcode == rvPkg::OP);
    assign isOpImm = (dec.opcode == rvPkg::OP_IMM);
    assign aluOp = rvPkg::aluOp_t'(dec.funct3);

    assign opB = isOp ? rs2Data : dec.immI; // immediate form uses immI
    assign upper = dec.funct7; // same bits as the shift imm top bits
    assign upperZero = (upper == 7'b0);
    assign upperAlt = (upper == rvPkg::FUNCT7_ALT);
    assign shamt = opB[4:0];

    assign unsignedLess = (rs1Data < opB);
    // differing signs decide on their own
    assign signedLess = (rs1Data[rvPkg::XLEN-1] != opB[rvPkg::XLEN-1]) ?
                        rs1Data[rvPkg::XLEN-1] : unsignedLess;

    assign srlValue = rs1Data >> shamt;
    assign sraValue = rs1Data[rvPkg::XLEN-1] ?
                      (srlValue | ~({rvPkg::XLEN{1'b1}} >> shamt)) : srlValue; // fill with sign

    always_comb begin
        case (aluOp)
            rvPkg::ALU_ADD:  result = (isOp && upperAlt) ? rs1Data - opB : rs1Data + opB;
            rvPkg::ALU_SLL:  result = rs1Data << shamt;
            rvPkg::ALU_SLT:  result = {{(rvPkg::XLEN-1){1'b0}}, signedLess};
            rvPkg::ALU_SLTU: result = {{(rvPkg::XLEN-1){1'b0}}, unsignedLess};
            rvPkg::ALU_XOR:  result = rs1Data ^ opB;
            rvPkg::ALU_SR:   result = upperAlt ? sraValue : srlValue;
            rvPkg::ALU_OR:   result = rs1Data | opB;
            rvPkg::ALU_AND:  result = rs1Data & opB;
            default:         result = '0;
        endcase
    end

    // legal encodings of the upper seven bits per funct3
    always_comb begin
        case (aluOp)
            rvPkg::ALU_ADD:  upperBad = isOp && !(upperZero || upperAlt); // addi takes any imm
            rvPkg::ALU_SR:   upperBad = !(upperZero || upperAlt);
            rvPkg::ALU_SLL:  upperBad = !upperZero;
            rvPkg::ALU_SLT:  upperBad = isOp && !upperZero;
            rvPkg::ALU_SLTU: upperBad = isOp && !upperZero;
            rvPkg::ALU_XOR:  upperBad = isOp && !upperZero;
            rvPkg::ALU_OR:   upperBad = isOp && !upperZero;
            rvPkg::ALU_AND:  upperBad = isOp && !upperZero;
            default:         upperBad = 1'b1; // unknown funct3
        endcase
    end

    assign illegal = (isOp || isOpImm) && upperBad; // other opcodes belong elsewhere

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input logic clk,
    input logic rst,
    input rvPkg::regAddr_t rs1,
    input rvPkg::regAddr_t rs2,
    output rvPkg::word_t rs1Data,
    output rvPkg::word_t rs2Data,
    input rvPkg::regAddr_t rd,
    input rvPkg::word_t rdData,
    input logic wen
);

    rvPkg::word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= rdData; // writes to x0 dropped
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    // the core must hold its write enable low through reset
    assert property (@(posedge clk) !rst |-> !wen)
        else $error("register write requested during reset");

endmodule

//--- src/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input rvPkg::word_t instWord,
    decodeIf.producer dec
);

    logic signBit;

    assign signBit = instWord[31]; // every immediate extends from bit 31

    // fixed field positions
    assign dec.opcode = rvPkg::opcode_t'(instWord[6:0]);
    assign dec.rd = instWord[11:7];
    assign dec.funct3 = instWord[14:12];
    assign dec.rs1 = instWord[19:15];
    assign dec.rs2 = instWord[24:20];
    assign dec.funct7 = instWord[31:25];

    // I type, loads jalr and op-imm
    assign dec.immI = {
        {20{signBit}},
        instWord[31:20]
    };

    // S type, split around rd position
    assign dec.immS = {
        {20{signBit}},
        instWord[31:25],
        instWord[11:7]
    };

    // B type, halfword offset
    assign dec.immB = {
        {19{signBit}},
        instWord[31],
        instWord[7],
        instWord[30:25],
        instWord[11:8],
        1'b0
    };

    // U type, low bits zero
    assign dec.immU = {
        instWord[31:12],
        12'b0
    };

    // J type, scrambled 20 bit offset
    assign dec.immJ = {
        {11{signBit}},
        instWord[31],
        instWord[19:12],
        instWord[20],
        instWord[30:21],
        1'b0
    };

endmodule

//--- src/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;

    rvPkg::opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    rvPkg::regAddr_t rs1;
    rvPkg::regAddr_t rs2;
    rvPkg::regAddr_t rd;

    // sign extended immediates, one per format
    rvPkg::word_t immI;
    rvPkg::word_t immS;
    rvPkg::word_t immB;
    rvPkg::word_t immU;
    rvPkg::word_t immJ;

    modport producer (
        output opcode, funct3, funct7, rs1, rs2, rd,
        output immI, immS, immB, immU, immJ
    );

    modport consumer (
        input opcode, funct3, funct7, rs1, rs2, rd,
        input immI, immS, immB, immU, immJ
    );

endinterface

//--- src/rvPkg.sv
package rvPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] regAddr_t;

    // major opcodes the core knows about
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    // funct3 for OP and OP_IMM
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000, // add, sub, addi
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101, // srl and sra share it
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } aluOp_t;

    // funct3 for BRANCH, codes 2 and 3 are unused
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branchOp_t;

    localparam logic [2:0] FUNCT3_WORD = 3'b010; // lw and sw
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // sub and sra
    localparam word_t INST_BYTES = 32'd4;

endpackage
